// ==== sdctrl_settings.svh ====
`ifndef SDCTRL_SETTINGS_SVH
`define SDCTRL_SETTINGS_SVH

// ---------------------------------------------------------------------------
// card clock
// ---------------------------------------------------------------------------

// controller clocks per card-clock half period.
`define SDCTRL_CLK_DIV 2

// ---------------------------------------------------------------------------
// command line timing
// ---------------------------------------------------------------------------

// power-up clocks with the command line held high.
`define SDCTRL_INIT_CYCLES 74

// card-clock rises to wait for the response start bit.
`define SDCTRL_NCR_MAX 64

`endif

// ==== sdctrl_pkg.sv ====
package sdctrl_pkg;

    // ------------------------------------------------------------------------
    // enums
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {
        RESP_NONE        = 2'd0,
        RESP_SHORT       = 2'd1,    // 48 bits with CRC7.
        RESP_SHORT_NOCRC = 2'd2,    // 48 bits, CRC field not checked.
        RESP_LONG        = 2'd3     // 136 bits, CRC7 over the CID/CSD body.
    } sd_resp_class_e;

    typedef enum logic [2:0] {
        INITIALISE = 3'd0,
        IDLE       = 3'd1,
        WRITECMD   = 3'd2,
        READ       = 3'd3,
        AWAIT      = 3'd4
    } sd_phy_state_e;

    // ------------------------------------------------------------------------
    // structs
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic [47:0]    cmd;
        sd_resp_class_e resp_class;
    } sd_cmd_req_t;

    typedef struct packed {
        logic level;
        logic rise;
        logic fall;
    } sd_clk_t;

    typedef struct packed {
        logic [135:0] data;                 // short frames are right-aligned.
        logic         crc_err;
        logic         timeout;
    } sd_resp_t;

endpackage

// ==== sdclkgen.sv ====
`timescale 1ns/1ps
`include "sdctrl_settings.svh"

module sdclkgen (
    input  logic                sdctrl_clock_i,
    input  logic                rst_i,
    output sdctrl_pkg::sd_clk_t sdclk_o
);

    localparam int CLK_DIV = `SDCTRL_CLK_DIV;
    localparam int CNT_W   = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [CNT_W-1:0] div_cnt;
    logic             level_q;
    logic             rise_q;
    logic             fall_q;

    always_ff @(posedge sdctrl_clock_i) begin
        if (rst_i) begin
            div_cnt <= '0;
            level_q <= 1'b1;                // card clock idles high.
            rise_q  <= 1'b0;
            fall_q  <= 1'b0;
        end else begin
            rise_q <= 1'b0;
            fall_q <= 1'b0;
            if (div_cnt == CNT_W'(CLK_DIV - 1)) begin
                div_cnt <= '0;
                level_q <= ~level_q;
                rise_q  <= ~level_q;        // strobes line up with the new level.
                fall_q  <= level_q;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    assign sdclk_o.level = level_q;
    assign sdclk_o.rise  = rise_q;
    assign sdclk_o.fall  = fall_q;

endmodule

// ==== sdcmd_tx.sv ====
`timescale 1ns/1ps

module sdcmd_tx (
    input  logic                sdctrl_clock_i,
    input  logic                rst_i,
    input  sdctrl_pkg::sd_clk_t clk_i,
    input  logic                load_i,
    input  logic [47:0]         cmd_i,
    output logic                cmd_o,
    output logic                oe_o,
    output logic                done_o
);

    logic [47:0] shreg;
    logic [5:0]  bit_cnt;
    logic        busy;

    // ------------------------------------------------------------------------
    // shift register
    // ------------------------------------------------------------------------

    always_ff @(posedge sdctrl_clock_i) begin
        if (load_i) begin
            shreg <= cmd_i;
        end else if (busy && clk_i.fall) begin
            shreg <= {shreg[46:0], 1'b0};   // next bit moves up to bit 47.
        end
    end

    // ------------------------------------------------------------------------
    // line control
    // ------------------------------------------------------------------------

    always_ff @(posedge sdctrl_clock_i) begin
        if (rst_i) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            cmd_o   <= 1'b1;
            oe_o    <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (load_i) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy && clk_i.fall) begin
                if (bit_cnt == 6'd48) begin
                    // the last bit has now been on the line for a full period.
                    busy   <= 1'b0;
                    cmd_o  <= 1'b1;
                    oe_o   <= 1'b0;
                    done_o <= 1'b1;
                end else begin
                    cmd_o   <= shreg[47];
                    oe_o    <= 1'b1;
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== sdresp_rx.sv ====
`timescale 1ns/1ps
`include "sdctrl_settings.svh"

module sdresp_rx (
    input  logic                       sdctrl_clock_i,
    input  logic                       rst_i,
    input  sdctrl_pkg::sd_clk_t        clk_i,
    input  logic                       arm_i,
    input  sdctrl_pkg::sd_resp_class_e class_i,
    input  logic                       resp_i,
    output sdctrl_pkg::sd_resp_t       result_o,
    output logic                       done_o
);
    import sdctrl_pkg::*;

    localparam int NCR_MAX = `SDCTRL_NCR_MAX;
    localparam int WAIT_W  = $clog2(NCR_MAX + 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_WAIT,
        RX_SHIFT,
        RX_CHECK
    } rx_state_e;

    rx_state_e         state;
    sd_resp_class_e    class_q;
    logic [WAIT_W-1:0] wait_cnt;
    logic [7:0]        bit_cnt;
    logic [7:0]        last_bit;
    logic [135:0]      shreg;
    logic [6:0]        crc;
    logic              crc_en;
    logic              crc_fb;
    logic              take_bit;
    logic              crc_err_q;
    logic              timeout_q;

    // bit_cnt counts received bits, so 0 is the start bit.
    assign last_bit = (class_q == RESP_LONG) ? 8'd135 : 8'd47;
    assign take_bit = clk_i.rise && ((state == RX_WAIT && !resp_i) || state == RX_SHIFT);
    assign crc_fb   = crc[6] ^ resp_i;

    always_comb begin
        if (class_q == RESP_LONG) begin
            crc_en = (bit_cnt >= 8'd8) && (bit_cnt <= 8'd127);  // frame bits 127 to 8.
        end else begin
            crc_en = (bit_cnt <= 8'd39);                        // frame bits 47 to 8.
        end
    end

    // ------------------------------------------------------------------------
    // frame capture and serial CRC7, x^7 + x^3 + 1
    // ------------------------------------------------------------------------

    always_ff @(posedge sdctrl_clock_i) begin
        if (arm_i) begin
            shreg <= '0;
            crc   <= '0;
        end else if (take_bit) begin
            shreg <= {shreg[134:0], resp_i};
            if (crc_en) begin
                crc <= {crc[5:3], crc[2] ^ crc_fb, crc[1:0], crc_fb};
            end
        end
    end

    // ------------------------------------------------------------------------
    // receive control
    // ------------------------------------------------------------------------

    always_ff @(posedge sdctrl_clock_i) begin
        if (rst_i) begin
            state     <= RX_IDLE;
            class_q   <= RESP_NONE;
            wait_cnt  <= '0;
            bit_cnt   <= '0;
            crc_err_q <= 1'b0;
            timeout_q <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (arm_i) begin
                state     <= RX_WAIT;
                class_q   <= class_i;
                wait_cnt  <= '0;
                bit_cnt   <= '0;
                crc_err_q <= 1'b0;
                timeout_q <= 1'b0;
            end else begin
                case (state)
                    RX_WAIT: begin
                        if (take_bit) begin
                            state   <= RX_SHIFT;
                            bit_cnt <= 8'd1;
                        end else if (clk_i.rise) begin
                            if (wait_cnt == WAIT_W'(NCR_MAX - 1)) begin
                                state     <= RX_IDLE;   // card never answered.
                                timeout_q <= 1'b1;
                                done_o    <= 1'b1;
                            end else begin
                                wait_cnt <= wait_cnt + 1'b1;
                            end
                        end
                    end
                    RX_SHIFT: begin
                        if (take_bit) begin
                            if (bit_cnt == last_bit) begin
                                state <= RX_CHECK;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                    RX_CHECK: begin
                        state     <= RX_IDLE;
                        crc_err_q <= (class_q != RESP_SHORT_NOCRC) && (crc != shreg[7:1]);
                        done_o    <= 1'b1;
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    assign result_o.data    = shreg;
    assign result_o.crc_err = crc_err_q;
    assign result_o.timeout = timeout_q;

endmodule

// ==== sdcmdphy.sv ====
`timescale 1ns/1ps
`include "sdctrl_settings.svh"

module sdcmdphy (
    input  logic                    sdctrl_clock_i,
    input  logic                    rst_i,
    input  sdctrl_pkg::sd_clk_t     clk_i,
    input  sdctrl_pkg::sd_cmd_req_t req_i,
    input  logic                    start_i,
    output logic                    ready_o,
    output sdctrl_pkg::sd_resp_t    resp_o,
    output logic                    finish_o,
    output logic                    cmd_o,
    output logic                    cmd_oe_o,
    input  logic                    resp_i
);
    import sdctrl_pkg::*;

    localparam int INIT_CYCLES = `SDCTRL_INIT_CYCLES;
    localparam int INIT_W      = $clog2(INIT_CYCLES + 1);

    sd_phy_state_e  state;
    sd_resp_class_e class_q;
    logic [INIT_W-1:0] init_cnt;
    logic           tx_load;
    logic           tx_done;
    logic           rx_arm;
    logic           rx_done;
    sd_resp_t       rx_result;
    sd_resp_t       resp_q;

    assign ready_o  = (state == IDLE);
    assign finish_o = (state == AWAIT);     // AWAIT lasts exactly one cycle.
    assign resp_o   = resp_q;
    assign tx_load  = ready_o && start_i;
    assign rx_arm   = (state == WRITECMD) && tx_done && (class_q != RESP_NONE);

    // ------------------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------------------

    always_ff @(posedge sdctrl_clock_i) begin
        if (rst_i) begin
            state    <= INITIALISE;
            class_q  <= RESP_NONE;
            init_cnt <= '0;
        end else begin
            case (state)
                INITIALISE: begin
                    if (clk_i.rise) begin
                        if (init_cnt == INIT_W'(INIT_CYCLES - 1)) begin
                            state <= IDLE;
                        end else begin
                            init_cnt <= init_cnt + 1'b1;
                        end
                    end
                end
                IDLE: begin
                    if (start_i) begin
                        class_q <= req_i.resp_class;
                        state   <= WRITECMD;
                    end
                end
                WRITECMD: begin
                    if (tx_done) begin
                        if (class_q == RESP_NONE) begin
                            state <= AWAIT;
                        end else begin
                            state <= READ;
                        end
                    end
                end
                READ: begin
                    if (rx_done) begin
                        state <= AWAIT;
                    end
                end
                AWAIT:   state <= IDLE;
                default: state <= INITIALISE;
            endcase
        end
    end

    // result for the requester, written as AWAIT is entered.
    always_ff @(posedge sdctrl_clock_i) begin
        if (state == WRITECMD && tx_done && class_q == RESP_NONE) begin
            resp_q <= '0;
        end else if (state == READ && rx_done) begin
            resp_q <= rx_result;
        end
    end

    // ------------------------------------------------------------------------
    // transmitter and receiver
    // ------------------------------------------------------------------------

    sdcmd_tx sdcmd_tx_inst (
        .sdctrl_clock_i (sdctrl_clock_i),
        .rst_i          (rst_i),
        .clk_i          (clk_i),
        .load_i         (tx_load),
        .cmd_i          (req_i.cmd),
        .cmd_o          (cmd_o),
        .oe_o           (cmd_oe_o),
        .done_o         (tx_done)
    );

    sdresp_rx sdresp_rx_inst (
        .sdctrl_clock_i (sdctrl_clock_i),
        .rst_i          (rst_i),
        .clk_i          (clk_i),
        .arm_i          (rx_arm),
        .class_i        (class_q),
        .resp_i         (resp_i),
        .result_o       (rx_result),
        .done_o         (rx_done)
    );

endmodule

// ==== sdctrl_top.sv ====
`timescale 1ns/1ps

module sdctrl_top (
    input  logic                    sdctrl_clock_i,
    input  logic                    rst_i,
    // requester side
    input  sdctrl_pkg::sd_cmd_req_t req_i,
    input  logic                    start_i,
    output logic                    ready_o,
    output sdctrl_pkg::sd_resp_t    resp_o,
    output logic                    finish_o,
    // card side
    output logic                    sdclk_o,
    output logic                    cmd_o,
    output logic                    cmd_oe_o,
    input  logic                    resp_i
);
    import sdctrl_pkg::*;

    sd_clk_t sd_clk;

    sdclkgen sdclkgen_inst (
        .sdctrl_clock_i (sdctrl_clock_i),
        .rst_i          (rst_i),
        .sdclk_o        (sd_clk)
    );

    sdcmdphy sdcmdphy_inst (
        .sdctrl_clock_i (sdctrl_clock_i),
        .rst_i          (rst_i),
        .clk_i          (sd_clk),
        .req_i          (req_i),
        .start_i        (start_i),
        .ready_o        (ready_o),
        .resp_o         (resp_o),
        .finish_o       (finish_o),
        .cmd_o          (cmd_o),
        .cmd_oe_o       (cmd_oe_o),
        .resp_i         (resp_i)
    );

    assign sdclk_o = sd_clk.level;          // the card sees only the level.

endmodule

// ==== sdctrl_assert.sv ====
`timescale 1ns/1ps

module sdctrl_assert (
    input logic                      sdctrl_clock_i,
    input logic                      rst_i,
    input logic                      start_i,
    input logic                      ready_i,
    input logic                      finish_i,
    input logic                      cmd_i,
    input logic                      cmd_oe_i,
    input sdctrl_pkg::sd_phy_state_e phy_state_i
);
    import sdctrl_pkg::*;

    finish_one_cycle: assert property (@(posedge sdctrl_clock_i) disable iff (rst_i)
        finish_i |=> !finish_i)
        else $error("finish_o stayed high for more than one cycle");

    cmd_high_in_init: assert property (@(posedge sdctrl_clock_i) disable iff (rst_i)
        (phy_state_i == INITIALISE) |-> cmd_i)
        else $error("command line left high level during initialisation");

    ready_oe_exclusive: assert property (@(posedge sdctrl_clock_i) disable iff (rst_i)
        !(ready_i && cmd_oe_i))
        else $error("ready_o and cmd_oe_o high together");

    start_clears_ready: assert property (@(posedge sdctrl_clock_i) disable iff (rst_i)
        (start_i && ready_i) |=> !ready_i)
        else $error("ready_o still high after an accepted start");

endmodule

bind sdctrl_top sdctrl_assert sdctrl_assert_inst (
    .sdctrl_clock_i (sdctrl_clock_i),
    .rst_i          (rst_i),
    .start_i        (start_i),
    .ready_i        (ready_o),
    .finish_i       (finish_o),
    .cmd_i          (cmd_o),
    .cmd_oe_i       (cmd_oe_o),
    .phy_state_i    (sdcmdphy_inst.state)
);

// ==== tb_sdctrl.sv ====
`timescale 1ns/1ps
`include "sdctrl_settings.svh"

module tb_sdctrl;
    import sdctrl_pkg::*;

    localparam int CARD_NS     = 2 * `SDCTRL_CLK_DIV * 40;
    localparam int N_XFER      = 20;
    localparam int XFER_CLOCKS = 48 + 20 + 136 + `SDCTRL_NCR_MAX + 16;
    localparam int WATCHDOG_NS = (`SDCTRL_INIT_CYCLES + N_XFER * XFER_CLOCKS + 100) * CARD_NS;

    logic        sdctrl_clock_i;
    logic        rst_i;
    sd_cmd_req_t cur_req;
    logic        start_i;
    logic        ready_o;
    sd_resp_t    resp_o;
    logic        finish_o;
    logic        sdclk_o;
    logic        cmd_o;
    logic        cmd_oe_o;
    logic        resp_i;

    sd_resp_t    cur_exp;
    logic        cur_silent;
    int          cur_delay;
    int          init_rises;
    logic        ready_seen;
    int          done_count;
    integer      seed;

    sdctrl_top sdctrl_top_inst (
        .sdctrl_clock_i (sdctrl_clock_i),
        .rst_i          (rst_i),
        .req_i          (cur_req),
        .start_i        (start_i),
        .ready_o        (ready_o),
        .resp_o         (resp_o),
        .finish_o       (finish_o),
        .sdclk_o        (sdclk_o),
        .cmd_o          (cmd_o),
        .cmd_oe_o       (cmd_oe_o),
        .resp_i         (resp_i)
    );

    initial begin : clock_gen
        sdctrl_clock_i = 1'b0;
        forever begin
            #20 sdctrl_clock_i = ~sdctrl_clock_i;
        end
    end

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    function automatic logic [6:0] crc7(input logic [135:0] frame, input int hi, input int lo);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = hi; i >= lo; i--) begin
            fb  = crc[6] ^ frame[i];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);  // x^7 + x^3 + 1.
        end
        return crc;
    endfunction

    function automatic sd_resp_t ref_resp(input sd_resp_class_e cls, input logic [133:0] body,
                                          input logic flip, input int flip_bit,
                                          input logic silent);
        sd_resp_t want;
        want = '0;
        if (cls != RESP_NONE && silent) begin
            want.timeout = 1'b1;                        // data stays zero.
        end else if (cls == RESP_LONG) begin
            want.data[133:128] = 6'h3f;
            want.data[127:8]   = body[119:0];
            want.data[7:1]     = crc7(want.data, 127, 8);
            want.data[0]       = 1'b1;
        end else if (cls != RESP_NONE) begin
            want.data[45:8] = body[37:0];               // start and transmission bits are 0.
            want.data[7:1]  = crc7(want.data, 47, 8);
            want.data[0]    = 1'b1;
        end
        if (cls != RESP_NONE && !silent && flip) begin
            want.data[1 + flip_bit] = ~want.data[1 + flip_bit];
            want.crc_err            = (cls != RESP_SHORT_NOCRC);
        end
        return want;
    endfunction

    task automatic compare_value(input logic [137:0] got, input logic [137:0] want,
                                 input string what);
        if (got !== want) begin
            $display("[FAIL] %0d ns: %s mismatch, got %h, expected %h", $time, what, got, want);
            $display("Result: FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // ------------------------------------------------------------------------
    // card model
    // ------------------------------------------------------------------------

    initial begin : card_model
        logic [47:0] got_cmd;
        int          nbits;
        int          len;
        resp_i     = 1'b1;
        init_rises = 0;
        got_cmd    = '0;
        nbits      = 0;
        forever begin
            @(posedge sdclk_o);
            if (!rst_i && !ready_seen && cmd_o && !cmd_oe_o) begin
                init_rises++;
            end
            if (cmd_oe_o) begin
                got_cmd = {got_cmd[46:0], cmd_o};
                nbits++;
                if (nbits == 48) begin
                    nbits = 0;
                    compare_value(138'(got_cmd), 138'(cur_req.cmd), "command bits");
                    if (cur_req.resp_class != RESP_NONE && !cur_silent) begin
                        len = (cur_req.resp_class == RESP_LONG) ? 136 : 48;
                        repeat (cur_delay) @(posedge sdclk_o);
                        for (int i = len - 1; i >= 0; i--) begin
                            @(negedge sdclk_o);
                            @(negedge sdctrl_clock_i);
                            resp_i = cur_exp.data[i];   // end bit leaves the line high.
                        end
                    end
                end
            end
        end
    end

    initial begin : compare_results
        done_count = 0;
        forever begin
            @(negedge sdctrl_clock_i);
            if (finish_o) begin
                compare_value(resp_o, cur_exp, "response record");
                done_count++;
            end
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    task automatic run_xfer(input sd_resp_class_e cls, input logic flip, input logic silent);
        logic [191:0] rnd;
        int           flip_bit;
        int           target;
        rnd = {$random(seed), $random(seed), $random(seed),
               $random(seed), $random(seed), $random(seed)};
        flip_bit = {$random(seed)} % 7;
        target   = done_count + 1;
        @(negedge sdctrl_clock_i);
        while (!ready_o) begin
            @(negedge sdctrl_clock_i);
        end
        cur_req.cmd        = rnd[191:144];
        cur_req.resp_class = cls;
        cur_silent         = silent;
        cur_delay          = 2 + {$random(seed)} % 19;
        cur_exp            = ref_resp(cls, rnd[133:0], flip, flip_bit, silent);
        start_i            = 1'b1;
        @(negedge sdctrl_clock_i);
        start_i = 1'b0;
        wait (done_count == target);
    endtask

    initial begin : stimulus
        seed       = 33395;
        rst_i      = 1'b1;
        start_i    = 1'b0;
        cur_req    = '0;
        cur_exp    = '0;
        cur_silent = 1'b0;
        cur_delay  = 2;
        ready_seen = 1'b0;
        repeat (2) @(posedge sdctrl_clock_i);
        @(negedge sdctrl_clock_i);
        rst_i = 1'b0;
        while (!ready_o) begin
            @(negedge sdctrl_clock_i);
        end
        ready_seen = 1'b1;
        compare_value(138'(init_rises >= `SDCTRL_INIT_CYCLES), 138'd1, "init clocks");
        for (int k = 0; k < 4; k++) begin
            run_xfer(RESP_SHORT, 1'b0, 1'b0);
            run_xfer(RESP_SHORT_NOCRC, 1'b0, 1'b0);
            run_xfer(RESP_LONG, 1'b0, 1'b0);
        end
        run_xfer(RESP_SHORT, 1'b1, 1'b0);
        run_xfer(RESP_SHORT_NOCRC, 1'b1, 1'b0);
        run_xfer(RESP_LONG, 1'b1, 1'b0);
        run_xfer(RESP_NONE, 1'b0, 1'b0);
        run_xfer(RESP_NONE, 1'b0, 1'b0);
        run_xfer(RESP_SHORT, 1'b0, 1'b1);
        run_xfer(RESP_LONG, 1'b0, 1'b1);
        run_xfer(RESP_SHORT, 1'b0, 1'b0);           // normal traffic after a timeout.
        $display("Result: PASSED");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the transfers did not complete in the expected time");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== list.f ====
+incdir+.
sdctrl_pkg.sv
sdclkgen.sv
sdcmd_tx.sv
sdresp_rx.sv
sdcmdphy.sv
sdctrl_top.sv
sdctrl_assert.sv
tb_sdctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_sdctrl -f list.f

output=$(./obj_dir/Vtb_sdctrl 2>&1 || true)
echo "$output"

if grep -q "^Result: PASSED$" <<< "$output"; then
    exit 0
else
    exit 1
fi
